// ==== rv_core.f ====
logic/riscv_isa_pkg.sv
logic/core_pkg.sv
logic/exec_ctrl_if.sv
logic/fetch_unit.sv
logic/instr_decoder.sv
logic/execute_unit.sv
logic/data_memory.sv
logic/register_file.sv
logic/rv_core_top.sv
verification/commit_checker.sv
verification/rv_core_tb.sv

// ==== Makefile ====
TOP := rv_core_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f rv_core.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f rv_core.f
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir

// ==== verification/rv_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;
  import riscv_isa_pkg::*;
  import core_pkg::*;

  localparam int num_tests = 5;
  localparam int setup_regs = 10;
  localparam int body_len = 40;
  localparam int prog_len = 2 * setup_regs + body_len + 1;
  localparam int reset_cycles = 16;
  localparam int halt_wait = 2 * prog_len + 20;
  localparam int test_cycles = prog_len + reset_cycles + halt_wait + 10;

  logic clock;
  logic reset;
  logic imem_write;
  logic [imem_addr_width-1:0] imem_addr;
  logic [instr_width-1:0] imem_data;
  logic commit_valid;
  logic [xlen-1:0] commit_pc;
  logic [instr_width-1:0] commit_instr;
  logic commit_wen;
  logic [reg_addr_width-1:0] commit_wdest;
  logic [xlen-1:0] commit_wdata;
  logic halted;
  logic [7:0] exit_code;
  logic [2:0] test_id;
  int check_errors;
  int tb_errors;
  logic [31:0] prog [$];

  initial begin
    clock = 1'b0;
    reset = 1'b1;
    imem_write = 1'b0;
    imem_addr = '0;
    imem_data = '0;
    test_id = '0;
    tb_errors = 0;
  end

  always #10 clock = ~clock;

  rv_core_top rv_core_top_i (
    .clock(clock),
    .reset(reset),
    .imem_write(imem_write),
    .imem_addr(imem_addr),
    .imem_data(imem_data),
    .commit_valid(commit_valid),
    .commit_pc(commit_pc),
    .commit_instr(commit_instr),
    .commit_wen(commit_wen),
    .commit_wdest(commit_wdest),
    .commit_wdata(commit_wdata),
    .halted(halted),
    .exit_code(exit_code)
  );

  commit_checker commit_checker_i (
    .clock(clock),
    .reset(reset),
    .test_id(test_id),
    .imem_write(imem_write),
    .imem_addr(imem_addr),
    .imem_data(imem_data),
    .commit_valid(commit_valid),
    .commit_pc(commit_pc),
    .commit_instr(commit_instr),
    .commit_wen(commit_wen),
    .commit_wdest(commit_wdest),
    .commit_wdata(commit_wdata),
    .halted(halted),
    .exit_code(exit_code),
    .error_count(check_errors)
  );

  // instruction encoders
  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, op_reg};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
  endfunction

  function automatic logic [4:0] random_reg();
    return 5'($urandom_range(setup_regs, 1));
  endfunction

  function automatic logic [2:0] pick_alu_f3();
    logic [2:0] pick [5];
    pick = '{funct3_add, funct3_slt, funct3_xor, funct3_or, funct3_and};
    return pick[$urandom_range(4, 0)];
  endfunction

  task automatic build_program(input int id);
    logic [2:0] f3;
    logic [4:0] rs;
    int fwd;
    prog.delete();
    // random operands in x1..x10
    for (int k = 1; k <= setup_regs; k++) begin
      prog.push_back({20'($urandom), 5'(k), op_lui});
      prog.push_back(i_type(12'($urandom), 5'(k), funct3_add, 5'(k), op_imm));
    end
    for (int i = 0; i < body_len; i++) begin
      case (id)
        0: begin
          f3 = 3'($urandom_range(7, 0));
          // sltu is outside the subset
          if (f3 == 3'b011) begin
            f3 = funct3_add;
          end
          prog.push_back(r_type(($urandom_range(1, 0) != 0 && f3 == funct3_add) ?
                                funct7_sub : 7'h00, random_reg(), random_reg(), f3,
                                random_reg()));
        end
        1: begin
          if ($urandom_range(4, 0) == 0) begin
            prog.push_back({20'($urandom), random_reg(), op_lui});
          end else begin
            prog.push_back(i_type(12'($urandom), random_reg(), pick_alu_f3(), random_reg(),
                                  op_imm));
          end
        end
        2: begin
          // first fill eight doublewords so every load reads stored data
          if (i < 8) begin
            prog.push_back(s_type(12'(8 * i), random_reg(), 5'd0, funct3_sd));
          end else begin
            case ($urandom_range(3, 0))
              0: prog.push_back(s_type(12'(8 * $urandom_range(7, 0)), random_reg(), 5'd0,
                                       funct3_sd));
              1: prog.push_back(s_type(12'($urandom_range(63, 0)), random_reg(), 5'd0,
                                       funct3_sb));
              2: prog.push_back(i_type(12'(8 * $urandom_range(7, 0)), 5'd0, funct3_ld,
                                       random_reg(), op_load));
              default: prog.push_back(i_type(12'($urandom_range(63, 0)), 5'd0, funct3_lbu,
                                             random_reg(), op_load));
            endcase
          end
        end
        3: begin
          // forward targets that stop at the halt
          fwd = $urandom_range((body_len - i < 4) ? body_len - i : 4, 1);
          rs = 5'($urandom_range(3, 1));
          case ($urandom_range(2, 0))
            0: prog.push_back(b_type(13'(4 * fwd), rs, 5'($urandom_range(3, 1)), funct3_beq));
            1: prog.push_back(b_type(13'(4 * fwd), rs, 5'($urandom_range(3, 1)), funct3_bne));
            default: prog.push_back(j_type(21'(4 * fwd), 5'($urandom_range(setup_regs, 0))));
          endcase
        end
        default: begin
          if (i % 2 == 0) begin
            case ($urandom_range(2, 0))
              0: prog.push_back(i_type(12'($urandom), random_reg(), funct3_add, 5'd0, op_imm));
              1: prog.push_back({20'($urandom), 5'd0, op_lui});
              default: prog.push_back(r_type(7'h00, random_reg(), random_reg(), funct3_or,
                                             5'd0));
            endcase
          end else begin
            prog.push_back(r_type(7'h00, 5'd0, 5'd0, funct3_add, random_reg()));
          end
        end
      endcase
    end
    prog.push_back({25'b0, op_halt});
  endtask

  task automatic run_test(input int id);
    int cycles;
    build_program(id);
    @(negedge clock);
    test_id = 3'(id);
    reset = 1'b1;
    for (int i = 0; i < prog.size(); i++) begin
      imem_write = 1'b1;
      imem_addr = imem_addr_width'(i);
      imem_data = prog[i];
      @(negedge clock);
    end
    imem_write = 1'b0;
    for (int i = prog.size(); i < reset_cycles; i++) begin
      @(negedge clock);
    end
    reset = 1'b0;
    cycles = 0;
    while (!halted && cycles < halt_wait) begin
      @(negedge clock);
      cycles++;
    end
    if (!halted) begin
      tb_errors++;
      $display("test %0d: core did not halt within %0d cycles", id, halt_wait);
    end
    // quiet period after halt
    repeat (5) @(negedge clock);
  endtask

  initial begin
    void'($urandom(35983));
    for (int id = 0; id < num_tests; id++) begin
      run_test(id);
    end
    @(negedge clock);
    reset = 1'b1;
    repeat (2) @(negedge clock);
    $display("errors: checker %0d, testbench %0d", check_errors, tb_errors);
    if (check_errors == 0 && tb_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  initial begin
    #(num_tests * test_cycles * 20);
    $display("watchdog expired before all tests finished");
    $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verification/commit_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module commit_checker (
  input  logic                                      clock,
  input  logic                                      reset,
  input  logic [2:0]                                test_id,
  input  logic                                      imem_write,
  input  logic [core_pkg::imem_addr_width-1:0]      imem_addr,
  input  logic [riscv_isa_pkg::instr_width-1:0]     imem_data,
  input  logic                                      commit_valid,
  input  logic [riscv_isa_pkg::xlen-1:0]            commit_pc,
  input  logic [riscv_isa_pkg::instr_width-1:0]     commit_instr,
  input  logic                                      commit_wen,
  input  logic [riscv_isa_pkg::reg_addr_width-1:0]  commit_wdest,
  input  logic [riscv_isa_pkg::xlen-1:0]            commit_wdata,
  input  logic                                      halted,
  input  logic [7:0]                                exit_code,
  output int                                        error_count
);
  import riscv_isa_pkg::*;
  import core_pkg::*;

  typedef struct packed {
    logic [63:0] pc;
    logic [31:0] instr;
    logic        wen;
    logic [4:0]  wdest;
    logic [63:0] wdata;
    logic        halt;
    logic [7:0]  exit_code;
  } commit_t;

  logic [31:0] prog [imem_depth];
  logic [63:0] dmem_model [dmem_depth];
  logic [63:0] ref_regs [32];
  logic [63:0] ref_pc;
  logic reset_q;
  logic halt_seen;
  commit_t exp;

  initial begin
    error_count = 0;
    halt_seen = 1'b0;
    ref_pc = reset_pc;
  end

  function automatic string test_name(input logic [2:0] id);
    case (id)
      3'd0: return "register_ops";
      3'd1: return "immediate_ops";
      3'd2: return "memory_ops";
      3'd3: return "branch_jump";
      default: return "x0_writes";
    endcase
  endfunction

  // arithmetic of the subset for register and immediate forms
  function automatic logic [63:0] alu_ref(input logic [2:0] f3, input logic sub,
                                          input logic [63:0] x, input logic [63:0] y);
    case (f3)
      funct3_add: return sub ? x - y : x + y;
      funct3_sll: return x << y[5:0];
      funct3_slt: return {63'b0, $signed(x) < $signed(y)};
      funct3_xor: return x ^ y;
      funct3_srl: return x >> y[5:0];
      funct3_or:  return x | y;
      default:    return x & y;
    endcase
  endfunction

  // executes one instruction on the model and returns its commit record
  function automatic commit_t ref_step();
    commit_t r;
    logic [31:0] ins;
    logic [6:0] opc;
    logic [2:0] f3;
    logic [4:0] rd;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] imm_i;
    logic [63:0] imm_s;
    logic [63:0] imm_b;
    logic [63:0] imm_j;
    logic [63:0] addr;
    logic [63:0] val;
    logic [63:0] next_pc;
    logic wr;
    ins = prog[ref_pc[2 +: imem_addr_width]];
    opc = ins[6:0];
    f3 = ins[14:12];
    rd = ins[11:7];
    a = ref_regs[ins[19:15]];
    b = ref_regs[ins[24:20]];
    imm_i = {{52{ins[31]}}, ins[31:20]};
    imm_s = {{52{ins[31]}}, ins[31:25], ins[11:7]};
    imm_b = {{51{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_j = {{43{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
    r = '0;
    val = '0;
    wr = 1'b0;
    next_pc = ref_pc + 64'd4;
    case (opc)
      op_reg: begin
        val = alu_ref(f3, ins[31:25] == funct7_sub, a, b);
        wr = 1'b1;
      end
      op_imm: begin
        val = alu_ref(f3, 1'b0, a, imm_i);
        wr = 1'b1;
      end
      op_lui: begin
        val = {{32{ins[31]}}, ins[31:12], 12'b0};
        wr = 1'b1;
      end
      op_load: begin
        addr = a + imm_i;
        val = dmem_model[addr[3 +: dmem_addr_width]];
        if (f3 == funct3_lbu) begin
          val = {56'b0, val[{addr[2:0], 3'b000} +: 8]};
        end
        wr = 1'b1;
      end
      op_store: begin
        addr = a + imm_s;
        if (f3 == funct3_sd) begin
          dmem_model[addr[3 +: dmem_addr_width]] = b;
        end else begin
          dmem_model[addr[3 +: dmem_addr_width]][{addr[2:0], 3'b000} +: 8] = b[7:0];
        end
      end
      op_branch: begin
        if ((a == b) != (f3 == funct3_bne)) begin
          next_pc = ref_pc + imm_b;
        end
      end
      op_jal: begin
        val = ref_pc + 64'd4;
        wr = 1'b1;
        next_pc = ref_pc + imm_j;
      end
      op_halt: begin
        r.halt = 1'b1;
        r.exit_code = ref_regs[10][7:0];
        next_pc = ref_pc;
      end
      default: ;
    endcase
    wr = wr && (rd != 5'd0);
    if (wr) begin
      ref_regs[rd] = val;
    end
    r.pc = ref_pc;
    r.instr = ins;
    r.wen = wr;
    r.wdest = rd;
    r.wdata = val;
    ref_pc = next_pc;
    return r;
  endfunction

  task automatic check_field(input string field, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      error_count++;
      $display("FAILED %s %s: expected %h, actual %h", test_name(test_id), field,
               expected, actual);
    end
  endtask

  // load port and reset are sampled where the DUT sees them
  always @(posedge clock) begin
    reset_q <= reset;
    if (reset && imem_write) begin
      prog[imem_addr] <= imem_data;
    end
  end

  // before the first rising edge the model stays in reset
  always @(negedge clock) begin
    if (reset_q !== 1'b0) begin
      ref_pc = reset_pc;
      halt_seen = 1'b0;
      for (int i = 0; i < 32; i++) begin
        ref_regs[i] = '0;
      end
    end else if (halt_seen) begin
      if (commit_valid) begin
        error_count++;
        $display("%s: a commit appeared after the core halted", test_name(test_id));
      end
      if (!halted) begin
        error_count++;
        $display("%s: halted dropped before reset", test_name(test_id));
      end
    end else if (!commit_valid) begin
      error_count++;
      $display("%s: no commit in a cycle before halt", test_name(test_id));
    end else begin
      exp = ref_step();
      check_field("commit_pc", exp.pc, commit_pc);
      check_field("commit_instr", {32'b0, exp.instr}, {32'b0, commit_instr});
      check_field("commit_wen", {63'b0, exp.wen}, {63'b0, commit_wen});
      if (exp.wen) begin
        check_field("commit_wdest", {59'b0, exp.wdest}, {59'b0, commit_wdest});
        check_field("commit_wdata", exp.wdata, commit_wdata);
      end
      check_field("halted", {63'b0, exp.halt}, {63'b0, halted});
      if (exp.halt) begin
        halt_seen = 1'b1;
        check_field("exit_code", {56'b0, exp.exit_code}, {56'b0, exit_code});
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/rv_core_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core_top (
  input  logic                                      clock,
  input  logic                                      reset,
  input  logic                                      imem_write,
  input  logic [core_pkg::imem_addr_width-1:0]      imem_addr,
  input  logic [riscv_isa_pkg::instr_width-1:0]     imem_data,
  output logic                                      commit_valid,
  output logic [riscv_isa_pkg::xlen-1:0]            commit_pc,
  output logic [riscv_isa_pkg::instr_width-1:0]     commit_instr,
  output logic                                      commit_wen,
  output logic [riscv_isa_pkg::reg_addr_width-1:0]  commit_wdest,
  output logic [riscv_isa_pkg::xlen-1:0]            commit_wdata,
  output logic                                      halted,
  output logic [7:0]                                exit_code
);
  import riscv_isa_pkg::*;
  import core_pkg::*;

  logic [xlen-1:0] pc;
  logic [instr_width-1:0] instr;
  logic take_branch;
  logic [xlen-1:0] branch_target;
  logic [reg_addr_width-1:0] rs1_addr;
  logic [reg_addr_width-1:0] rs2_addr;
  logic [xlen-1:0] rs1_data;
  logic [xlen-1:0] rs2_data;
  logic [xlen-1:0] alu_result;
  logic [xlen-1:0] load_data;
  logic [xlen-1:0] wb_data;
  logic rd_wen;
  logic fetch_hold;

  exec_ctrl_if ctrl_if ();

  // pc stops on the halt instruction itself
  assign fetch_hold = halted || ctrl_if.is_halt;

  fetch_unit fetch_unit_i (
    .clock(clock),
    .reset(reset),
    .imem_write(imem_write),
    .imem_addr(imem_addr),
    .imem_data(imem_data),
    .halted(fetch_hold),
    .take_branch(take_branch),
    .branch_target(branch_target),
    .pc(pc),
    .instr(instr)
  );

  instr_decoder instr_decoder_i (
    .instr(instr),
    .pc(pc),
    .rs1_addr(rs1_addr),
    .rs2_addr(rs2_addr),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .ctrl(ctrl_if)
  );

  execute_unit execute_unit_i (
    .ctrl(ctrl_if),
    .pc(pc),
    .alu_result(alu_result),
    .take_branch(take_branch),
    .branch_target(branch_target)
  );

  data_memory data_memory_i (
    .clock(clock),
    .ctrl(ctrl_if),
    .addr(alu_result),
    .load_data(load_data)
  );

  register_file register_file_i (
    .clock(clock),
    .reset(reset),
    .rs1_addr(rs1_addr),
    .rs2_addr(rs2_addr),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .write_enable(rd_wen),
    .write_addr(ctrl_if.rd_addr),
    .write_data(wb_data)
  );

  always_comb begin
    case (ctrl_if.wb_sel)
      wb_alu:  wb_data = alu_result;
      wb_mem:  wb_data = load_data;
      wb_pc4:  wb_data = pc + 64'd4;
      default: wb_data = '0;
    endcase
  end

  assign rd_wen = ctrl_if.rd_write && !halted;

  always_ff @(posedge clock) begin
    if (reset) begin
      commit_valid <= 1'b0;
      commit_wen   <= 1'b0;
      halted       <= 1'b0;
      exit_code    <= '0;
    end else begin
      commit_valid <= !halted;
      commit_wen   <= rd_wen;
      if (!halted && ctrl_if.is_halt) begin
        halted    <= 1'b1;
        // op_a carries x10 on a halt
        exit_code <= ctrl_if.op_a[7:0];
      end
    end
  end

  always_ff @(posedge clock) begin
    commit_pc    <= pc;
    commit_instr <= instr;
    commit_wdest <= ctrl_if.rd_addr;
    commit_wdata <= wb_data;
  end

  a_pc_frozen_after_halt : assert property (
    @(posedge clock) disable iff (reset) halted |=> $stable(pc)
  ) else $error("pc moved after halt");

endmodule

`default_nettype wire

// ==== logic/register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module register_file (
  input  logic                                      clock,
  input  logic                                      reset,
  input  logic [riscv_isa_pkg::reg_addr_width-1:0]  rs1_addr,
  input  logic [riscv_isa_pkg::reg_addr_width-1:0]  rs2_addr,
  output logic [riscv_isa_pkg::xlen-1:0]            rs1_data,
  output logic [riscv_isa_pkg::xlen-1:0]            rs2_data,
  input  logic                                      write_enable,
  input  logic [riscv_isa_pkg::reg_addr_width-1:0]  write_addr,
  input  logic [riscv_isa_pkg::xlen-1:0]            write_data
);
  import riscv_isa_pkg::*;

  logic [xlen-1:0] regs [32];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (write_enable && write_addr != '0) begin
      regs[write_addr] <= write_data;
    end
  end

  // x0 reads as zero
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

  a_no_x0_write : assert property (
    @(posedge clock) disable iff (reset) write_enable |-> write_addr != '0
  ) else $error("write to x0 enabled");

endmodule

`default_nettype wire

// ==== logic/data_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_memory (
  input  logic                            clock,
  exec_ctrl_if.consumer                   ctrl,
  input  logic [riscv_isa_pkg::xlen-1:0]  addr,
  output logic [riscv_isa_pkg::xlen-1:0]  load_data
);
  import riscv_isa_pkg::*;
  import core_pkg::*;

  logic [xlen-1:0] dmem [dmem_depth];
  logic [dmem_addr_width-1:0] word_index;
  logic [2:0] byte_lane;
  logic [5:0] lane_offset;
  logic [xlen-1:0] mem_word;

  // low bits below the access size are ignored
  assign word_index  = addr[3 +: dmem_addr_width];
  assign byte_lane   = addr[2:0];
  assign lane_offset = {byte_lane, 3'b000};
  assign mem_word    = dmem[word_index];

  always_ff @(posedge clock) begin
    if (ctrl.mem_write) begin
      if (ctrl.mem_size == mem_byte) begin
        dmem[word_index][lane_offset +: 8] <= ctrl.store_data[7:0];
      end else begin
        dmem[word_index] <= ctrl.store_data;
      end
    end
  end

  // lbu zero-extends the selected lane
  always_comb begin
    if (!ctrl.mem_read) begin
      load_data = '0;
    end else if (ctrl.mem_size == mem_byte) begin
      load_data = {{(xlen-8){1'b0}}, mem_word[lane_offset +: 8]};
    end else begin
      load_data = mem_word;
    end
  end

endmodule

`default_nettype wire

// ==== logic/execute_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
  exec_ctrl_if.consumer                   ctrl,
  input  logic [riscv_isa_pkg::xlen-1:0]  pc,
  output logic [riscv_isa_pkg::xlen-1:0]  alu_result,
  output logic                            take_branch,
  output logic [riscv_isa_pkg::xlen-1:0]  branch_target
);
  import riscv_isa_pkg::*;
  import core_pkg::*;

  logic [shamt_width-1:0] shamt;
  logic operands_equal;
  logic branch_taken;

  // shift amount is taken modulo the data width
  assign shamt = ctrl.op_b[shamt_width-1:0];

  always_comb begin
    case (ctrl.alu_op)
      alu_add:    alu_result = ctrl.op_a + ctrl.op_b;
      alu_sub:    alu_result = ctrl.op_a - ctrl.op_b;
      alu_and:    alu_result = ctrl.op_a & ctrl.op_b;
      alu_or:     alu_result = ctrl.op_a | ctrl.op_b;
      alu_xor:    alu_result = ctrl.op_a ^ ctrl.op_b;
      alu_slt: begin
        alu_result = {{(xlen-1){1'b0}}, $signed(ctrl.op_a) < $signed(ctrl.op_b)};
      end
      alu_sll:    alu_result = ctrl.op_a << shamt;
      alu_srl:    alu_result = ctrl.op_a >> shamt;
      alu_pass_b: alu_result = ctrl.op_b;
      default:    alu_result = '0;
    endcase
  end

  // branches carry rs1 and rs2 in op_a and op_b
  assign operands_equal = (ctrl.op_a == ctrl.op_b);
  assign branch_taken   = ctrl.is_branch && (operands_equal != ctrl.branch_ne);

  assign take_branch   = ctrl.is_jal || branch_taken;
  assign branch_target = pc + ctrl.imm;

  always_comb begin
    a_no_store_on_redirect : assert final (!(take_branch && ctrl.mem_write))
      else $error("redirect together with a store");
  end

endmodule

`default_nettype wire

// ==== logic/instr_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
  input  logic [riscv_isa_pkg::instr_width-1:0]     instr,
  input  logic [riscv_isa_pkg::xlen-1:0]            pc,
  output logic [riscv_isa_pkg::reg_addr_width-1:0]  rs1_addr,
  output logic [riscv_isa_pkg::reg_addr_width-1:0]  rs2_addr,
  input  logic [riscv_isa_pkg::xlen-1:0]            rs1_data,
  input  logic [riscv_isa_pkg::xlen-1:0]            rs2_data,
  exec_ctrl_if.decoder                              ctrl
);
  import riscv_isa_pkg::*;
  import core_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [reg_addr_width-1:0] rd;
  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_s;
  logic [xlen-1:0] imm_b;
  logic [xlen-1:0] imm_u;
  logic [xlen-1:0] imm_j;
  alu_op_e f3_op;
  logic f3_known;
  logic f3_shift;

  assign opcode = instr[6:0];
  assign rd     = instr[11:7];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign imm_i = {{(xlen-12){instr[31]}}, instr[31:20]};
  assign imm_s = {{(xlen-12){instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{(xlen-12){instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {{(xlen-32){instr[31]}}, instr[31:12], 12'b0};
  assign imm_j = {{(xlen-20){instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  // halt reads a0 through the rs1 port
  assign rs1_addr = (opcode == op_halt) ? exit_reg : instr[19:15];
  assign rs2_addr = instr[24:20];

  always_comb begin
    f3_known = 1'b1;
    f3_shift = 1'b0;
    case (funct3)
      funct3_add: f3_op = (opcode == op_reg && funct7 == funct7_sub) ? alu_sub : alu_add;
      funct3_slt: f3_op = alu_slt;
      funct3_xor: f3_op = alu_xor;
      funct3_or:  f3_op = alu_or;
      funct3_and: f3_op = alu_and;
      funct3_sll: begin
        f3_op    = alu_sll;
        f3_shift = 1'b1;
      end
      funct3_srl: begin
        f3_op    = alu_srl;
        f3_shift = 1'b1;
      end
      default: begin
        f3_op    = alu_add;
        f3_known = 1'b0;
      end
    endcase
  end

  always_comb begin
    ctrl.op_a       = rs1_data;
    ctrl.op_b       = rs2_data;
    ctrl.store_data = rs2_data;
    ctrl.imm        = '0;
    ctrl.alu_op     = alu_add;
    ctrl.wb_sel     = wb_none;
    ctrl.mem_read   = 1'b0;
    ctrl.mem_write  = 1'b0;
    ctrl.mem_size   = mem_dword;
    ctrl.is_branch  = 1'b0;
    ctrl.branch_ne  = 1'b0;
    ctrl.is_jal     = 1'b0;
    ctrl.is_halt    = 1'b0;
    ctrl.rd_write   = 1'b0;
    ctrl.rd_addr    = rd;
    case (opcode)
      op_reg: begin
        ctrl.alu_op   = f3_op;
        ctrl.wb_sel   = wb_alu;
        ctrl.rd_write = f3_known;
      end
      op_imm: begin
        ctrl.op_b     = imm_i;
        ctrl.imm      = imm_i;
        ctrl.alu_op   = f3_op;
        ctrl.wb_sel   = wb_alu;
        // no shift-immediate forms here
        ctrl.rd_write = f3_known && !f3_shift;
      end
      op_lui: begin
        ctrl.op_a     = '0;
        ctrl.op_b     = imm_u;
        ctrl.imm      = imm_u;
        ctrl.alu_op   = alu_pass_b;
        ctrl.wb_sel   = wb_alu;
        ctrl.rd_write = 1'b1;
      end
      op_load: begin
        ctrl.op_b     = imm_i;
        ctrl.imm      = imm_i;
        ctrl.wb_sel   = wb_mem;
        ctrl.mem_size = (funct3 == funct3_lbu) ? mem_byte : mem_dword;
        ctrl.mem_read = (funct3 == funct3_ld) || (funct3 == funct3_lbu);
        ctrl.rd_write = (funct3 == funct3_ld) || (funct3 == funct3_lbu);
      end
      op_store: begin
        ctrl.op_b      = imm_s;
        ctrl.imm       = imm_s;
        ctrl.mem_size  = (funct3 == funct3_sb) ? mem_byte : mem_dword;
        ctrl.mem_write = (funct3 == funct3_sd) || (funct3 == funct3_sb);
      end
      op_branch: begin
        ctrl.imm       = imm_b;
        ctrl.alu_op    = alu_sub;
        ctrl.is_branch = (funct3 == funct3_beq) || (funct3 == funct3_bne);
        ctrl.branch_ne = (funct3 == funct3_bne);
      end
      op_jal: begin
        ctrl.op_a     = pc;
        ctrl.op_b     = imm_j;
        ctrl.imm      = imm_j;
        ctrl.is_jal   = 1'b1;
        ctrl.wb_sel   = wb_pc4;
        ctrl.rd_write = 1'b1;
      end
      op_halt: begin
        ctrl.is_halt = 1'b1;
      end
      default: begin
        ctrl.rd_write = 1'b0;
      end
    endcase
    // x0 is never written
    if (rd == '0) begin
      ctrl.rd_write = 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== logic/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
  input  logic                                   clock,
  input  logic                                   reset,
  input  logic                                   imem_write,
  input  logic [core_pkg::imem_addr_width-1:0]   imem_addr,
  input  logic [riscv_isa_pkg::instr_width-1:0]  imem_data,
  input  logic                                   halted,
  input  logic                                   take_branch,
  input  logic [riscv_isa_pkg::xlen-1:0]         branch_target,
  output logic [riscv_isa_pkg::xlen-1:0]         pc,
  output logic [riscv_isa_pkg::instr_width-1:0]  instr
);
  import riscv_isa_pkg::*;
  import core_pkg::*;

  logic [instr_width-1:0] imem [imem_depth];
  logic [xlen-1:0] pc_next;

  // program load port, only open while the core is held in reset
  always_ff @(posedge clock) begin
    if (reset && imem_write) begin
      imem[imem_addr] <= imem_data;
    end
  end

  // word index wraps at the memory depth
  assign instr = imem[pc[2 +: imem_addr_width]];

  always_comb begin
    if (halted) begin
      pc_next = pc;
    end else if (take_branch) begin
      pc_next = branch_target;
    end else begin
      pc_next = pc + 64'd4;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= reset_pc;
    end else begin
      pc <= pc_next;
    end
  end

  a_load_only_in_reset : assert property (@(posedge clock) imem_write |-> reset)
    else $error("program load outside reset");

endmodule

`default_nettype wire

// ==== logic/exec_ctrl_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface exec_ctrl_if;
  import riscv_isa_pkg::*;
  import core_pkg::*;

  logic [xlen-1:0] op_a;
  logic [xlen-1:0] op_b;
  logic [xlen-1:0] store_data;
  logic [xlen-1:0] imm;
  alu_op_e alu_op;
  wb_sel_e wb_sel;
  logic mem_read;
  logic mem_write;
  mem_size_e mem_size;
  logic is_branch;
  logic branch_ne;
  logic is_jal;
  logic is_halt;
  logic rd_write;
  logic [reg_addr_width-1:0] rd_addr;

  modport decoder (
    output op_a, op_b, store_data, imm, alu_op, wb_sel, mem_read, mem_write, mem_size,
           is_branch, branch_ne, is_jal, is_halt, rd_write, rd_addr
  );

  modport consumer (
    input op_a, op_b, store_data, imm, alu_op, wb_sel, mem_read, mem_write, mem_size,
          is_branch, branch_ne, is_jal, is_halt, rd_write, rd_addr
  );

endinterface

`default_nettype wire

// ==== logic/core_pkg.sv ====
`default_nettype none

package core_pkg;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_sll,
    alu_srl,
    alu_pass_b
  } alu_op_e;

  typedef enum logic [1:0] {
    wb_alu,
    wb_mem,
    wb_pc4,
    wb_none
  } wb_sel_e;

  typedef enum logic {
    mem_byte,
    mem_dword
  } mem_size_e;

  // instruction words
  localparam int imem_depth = 256;
  localparam int imem_addr_width = $clog2(imem_depth);

  // doublewords
  localparam int dmem_depth = 512;
  localparam int dmem_addr_width = $clog2(dmem_depth);

endpackage

`default_nettype wire

// ==== logic/riscv_isa_pkg.sv ====
`default_nettype none

package riscv_isa_pkg;

  localparam int xlen = 64;
  localparam int instr_width = 32;
  localparam int reg_addr_width = 5;
  localparam int shamt_width = 6;

  localparam logic [xlen-1:0] reset_pc = '0;

  // a0 holds the exit code at halt
  localparam logic [reg_addr_width-1:0] exit_reg = 5'd10;

  localparam logic [6:0] op_imm    = 7'h13;
  localparam logic [6:0] op_reg    = 7'h33;
  localparam logic [6:0] op_lui    = 7'h37;
  localparam logic [6:0] op_load   = 7'h03;
  localparam logic [6:0] op_store  = 7'h23;
  localparam logic [6:0] op_branch = 7'h63;
  localparam logic [6:0] op_jal    = 7'h6f;
  localparam logic [6:0] op_halt   = 7'h6b;

  // arithmetic, shared by register and immediate forms
  localparam logic [2:0] funct3_add = 3'b000;
  localparam logic [2:0] funct3_sll = 3'b001;
  localparam logic [2:0] funct3_slt = 3'b010;
  localparam logic [2:0] funct3_xor = 3'b100;
  localparam logic [2:0] funct3_srl = 3'b101;
  localparam logic [2:0] funct3_or  = 3'b110;
  localparam logic [2:0] funct3_and = 3'b111;

  localparam logic [2:0] funct3_ld  = 3'b011;
  localparam logic [2:0] funct3_lbu = 3'b100;
  localparam logic [2:0] funct3_sd  = 3'b011;
  localparam logic [2:0] funct3_sb  = 3'b000;
  localparam logic [2:0] funct3_beq = 3'b000;
  localparam logic [2:0] funct3_bne = 3'b001;

  localparam logic [6:0] funct7_sub = 7'h20;

endpackage

`default_nettype wire
